// ==== design/loopSeq_settings.svh ====
`ifndef LOOPSEQ_SETTINGS_SVH
`define LOOPSEQ_SETTINGS_SVH

// program address width
`define LOOP_ADDR_W 18

// termination condition code width
`define LOOP_COND_W 4

// loop counter width, a count of 0 gives 2**LOOP_CNT_W passes
`define LOOP_CNT_W 14

// entries per stack, power of two only
`define LOOP_DEPTH 4

`endif

// ==== design/loopSeqPkg.sv ====
`default_nettype none

`include "loopSeq_settings.svh"

package loopSeqPkg;

  // termination condition of a loop entry
  typedef enum logic [`LOOP_COND_W-1:0] {
    condForever = `LOOP_COND_W'd0,  // never exits
    condCe      = `LOOP_COND_W'd1,  // counter expired
    condFlag    = `LOOP_COND_W'd2   // exit on flagIn
  } loopCondE;

  // one loop stack entry, 22 bits wide
  typedef struct packed {
    logic [`LOOP_ADDR_W-1:0] endAddr;
    logic [`LOOP_COND_W-1:0] cond;  // loopCondE code, unknown codes run forever
  } loopEntryT;

  // one counter stack entry
  typedef logic [`LOOP_CNT_W-1:0] loopCntT;

  // registered end-of-loop event
  typedef struct packed {
    logic                    loopBack;
    logic                    loopExit;
    logic [`LOOP_ADDR_W-1:0] endAddr;  // end address of the loop that fired
  } loopEventT;

endpackage

`default_nettype wire

// ==== design/hwStack.sv ====
`timescale 1ns/1ps
`default_nettype none

module hwStack #(
  parameter type payloadT = logic [7:0],
  parameter int  depth    = 4
) (
  input  wire          LPSCLK,
  input  wire          T_RST,
  input  wire          clkEnb,    // high freezes the stack
  input  wire          push,
  input  wire          pop,
  input  wire          writeTop,  // replace top in place
  input  wire payloadT din,
  output payloadT      top,
  output logic         full,
  output logic         empty,
  output logic         has1
);

  localparam int addrW = $clog2(depth);

  logic [addrW:0]   ptr;     // all ones when empty
  logic [addrW:0]   ptrInc;
  logic [addrW:0]   ptrDec;
  logic [addrW-1:0] wrAddr;
  logic             wrEn;
  logic             enb;

  payloadT mem [depth];

  assign enb    = !clkEnb;
  assign ptrInc = ptr + 1'b1;
  assign ptrDec = ptr - 1'b1;

  // push lands one above the current top, writeTop on it
  assign wrAddr = push ? ptrInc[addrW-1:0] : ptr[addrW-1:0];
  assign wrEn   = enb && (push || writeTop);

  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1;
    end else if (enb) begin
      if (push) begin
        ptr <= ptrInc;
      end else if (pop) begin
        ptr <= ptrDec;
      end
    end
  end

  always_ff @(posedge LPSCLK) begin
    if (wrEn) begin
      mem[wrAddr] <= din;
    end
  end

  assign top   = mem[ptr[addrW-1:0]];  // undefined while empty
  assign empty = ptr[addrW];
  assign full  = (ptr == (addrW + 1)'(depth - 1));
  assign has1  = (ptr == '0);

  // the controller qualifies every strobe against the flags
  aNoPushFull : assert property (
    @(posedge LPSCLK) disable iff (T_RST)
    (enb && push) |-> !full
  ) else $error("hwStack: push while full");

  aNoPopEmpty : assert property (
    @(posedge LPSCLK) disable iff (T_RST)
    (enb && pop) |-> !empty
  ) else $error("hwStack: pop while empty");

  aOneOp : assert property (
    @(posedge LPSCLK) disable iff (T_RST)
    enb |-> $onehot0({push, pop, writeTop})
  ) else $error("hwStack: more than one operation in a cycle");

endmodule

`default_nettype wire

// ==== design/loopCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loopSeq_settings.svh"

module loopCtrl (
  input  wire                       LPSCLK,
  input  wire                       T_RST,
  input  wire                       clkEnb,
  input  wire                       pushLoop,
  input  wire                       popLoop,
  input  wire loopSeqPkg::loopEntryT newEntry,
  input  wire loopSeqPkg::loopCntT   newCount,
  input  wire                       pcValid,
  input  wire [`LOOP_ADDR_W-1:0]    pc,
  input  wire                       flagIn,
  input  wire loopSeqPkg::loopEntryT loopTop,
  input  wire                       loopFull,
  input  wire                       loopEmpty,
  input  wire loopSeqPkg::loopCntT   cntTop,
  input  wire                       cntFull,
  input  wire                       cntHas1,
  output logic                      loopPush,
  output logic                      loopPop,
  output logic                      cntPush,
  output logic                      cntPop,
  output logic                      cntWriteTop,
  output loopSeqPkg::loopCntT        cntDin,
  output loopSeqPkg::loopEventT      evt,
  output logic                      overflow
);

  logic enb;
  logic newIsCe;
  logic topIsCe;
  logic pushReq;
  logic pushRefused;
  logic popReq;
  logic endHit;
  logic exitCond;
  logic doExit;
  logic doBack;

  assign enb     = !clkEnb;
  assign newIsCe = (newEntry.cond == loopSeqPkg::condCe);
  assign topIsCe = (loopTop.cond == loopSeqPkg::condCe);

  // push beats pop beats the end-address compare
  assign pushReq     = enb && pushLoop;
  assign pushRefused = pushReq && (loopFull || (newIsCe && cntFull));
  assign popReq      = enb && !pushLoop && popLoop && !loopEmpty;
  assign endHit      = enb && !pushLoop && !popLoop && pcValid && !loopEmpty
                       && (pc == loopTop.endAddr);

  always_comb begin
    case (loopTop.cond)
      loopSeqPkg::condCe:   exitCond = (cntTop == loopSeqPkg::loopCntT'(1));
      loopSeqPkg::condFlag: exitCond = flagIn;
      default:              exitCond = 1'b0;  // forever and unused codes
    endcase
  end

  assign doExit = endHit && exitCond;
  assign doBack = endHit && !exitCond;

  assign loopPush    = pushReq && !pushRefused;
  assign cntPush     = loopPush && newIsCe;  // only counted loops carry a count
  assign loopPop     = popReq || doExit;
  assign cntPop      = loopPop && topIsCe;
  assign cntWriteTop = doBack && topIsCe;    // decrement in place, 0 wraps
  assign cntDin      = cntPush ? newCount : cntTop - 1'b1;

  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      evt <= '0;
    end else begin
      evt.loopBack <= doBack;
      evt.loopExit <= doExit;
      evt.endAddr  <= endHit ? loopTop.endAddr : '0;
    end
  end

  // sticky until reset
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      overflow <= 1'b0;
    end else if (pushRefused) begin
      overflow <= 1'b1;
    end
  end

  aEvtExclusive : assert property (
    @(posedge LPSCLK) disable iff (T_RST)
    !(evt.loopBack && evt.loopExit)
  ) else $error("loopCtrl: loopBack and loopExit together");

  // once the last count leaves, the new top entry cannot be a counted loop
  aNoDecAfterLast : assert property (
    @(posedge LPSCLK) disable iff (T_RST)
    (cntPop && cntHas1) |=> !cntWriteTop
  ) else $error("loopCtrl: decrement on an empty counter stack");

endmodule

`default_nettype wire

// ==== design/loopSeqTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loopSeq_settings.svh"

module loopSeqTop (
  input  wire                       LPSCLK,
  input  wire                       T_RST,
  input  wire                       clkEnb,    // high holds all state
  input  wire                       pushLoop,
  input  wire loopSeqPkg::loopEntryT newEntry,
  input  wire loopSeqPkg::loopCntT   newCount,
  input  wire                       popLoop,
  input  wire                       pcValid,
  input  wire [`LOOP_ADDR_W-1:0]    pc,
  input  wire                       flagIn,
  output loopSeqPkg::loopEventT      evt,
  output loopSeqPkg::loopEntryT      topEntry,
  output loopSeqPkg::loopCntT        topCount,
  output logic                      stkEmpty,
  output logic                      stkFull,
  output logic                      overflow
);

  loopSeqPkg::loopEntryT loopTop;
  loopSeqPkg::loopCntT   cntTop;
  loopSeqPkg::loopCntT   cntDin;

  logic loopPush;
  logic loopPop;
  logic loopFull;
  logic loopEmpty;
  logic cntPush;
  logic cntPop;
  logic cntWriteTop;
  logic cntFull;
  logic cntHas1;

  hwStack #(
    .payloadT (loopSeqPkg::loopEntryT),
    .depth    (`LOOP_DEPTH)
  ) loopStk (
    .LPSCLK   (LPSCLK),
    .T_RST    (T_RST),
    .clkEnb   (clkEnb),
    .push     (loopPush),
    .pop      (loopPop),
    .writeTop (1'b0),      // entries are never edited in place
    .din      (newEntry),
    .top      (loopTop),
    .full     (loopFull),
    .empty    (loopEmpty),
    .has1     ()
  );

  hwStack #(
    .payloadT (loopSeqPkg::loopCntT),
    .depth    (`LOOP_DEPTH)
  ) cntStk (
    .LPSCLK   (LPSCLK),
    .T_RST    (T_RST),
    .clkEnb   (clkEnb),
    .push     (cntPush),
    .pop      (cntPop),
    .writeTop (cntWriteTop),
    .din      (cntDin),
    .top      (cntTop),
    .full     (cntFull),
    .empty    (),
    .has1     (cntHas1)
  );

  loopCtrl ctrl (
    .LPSCLK      (LPSCLK),
    .T_RST       (T_RST),
    .clkEnb      (clkEnb),
    .pushLoop    (pushLoop),
    .popLoop     (popLoop),
    .newEntry    (newEntry),
    .newCount    (newCount),
    .pcValid     (pcValid),
    .pc          (pc),
    .flagIn      (flagIn),
    .loopTop     (loopTop),
    .loopFull    (loopFull),
    .loopEmpty   (loopEmpty),
    .cntTop      (cntTop),
    .cntFull     (cntFull),
    .cntHas1     (cntHas1),
    .loopPush    (loopPush),
    .loopPop     (loopPop),
    .cntPush     (cntPush),
    .cntPop      (cntPop),
    .cntWriteTop (cntWriteTop),
    .cntDin      (cntDin),
    .evt         (evt),
    .overflow    (overflow)
  );

  assign topEntry = loopTop;
  assign topCount = cntTop;
  assign stkEmpty = loopEmpty;
  assign stkFull  = loopFull;  // counter stack never holds more than the loop stack

endmodule

`default_nettype wire

// ==== tb/loopSeqClkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module loopSeqClkGen #(
  parameter int period = 4  // ns
) (
  output logic LPSCLK
);

  initial begin
    LPSCLK = 1'b0;
    forever begin
      #(period / 2) LPSCLK = ~LPSCLK;
    end
  end

endmodule

`default_nettype wire

// ==== tb/loopSeqTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loopSeq_settings.svh"

module loopSeqTb;

  typedef struct packed {
    logic                    clkEnb;
    logic                    pushLoop;
    logic                    popLoop;
    loopSeqPkg::loopEntryT   entry;
    loopSeqPkg::loopCntT     count;
    logic                    pcValid;
    logic [`LOOP_ADDR_W-1:0] pc;
    logic                    flag;
  } stimT;

  typedef struct packed {
    loopSeqPkg::loopEventT evt;
    loopSeqPkg::loopEntryT entry;
    loopSeqPkg::loopCntT   count;
    logic                  cntValid;  // counter stack holds something
    logic                  empty;
    logic                  full;
    logic                  ovf;
  } expT;

  wire                     LPSCLK;
  logic                    T_RST;
  logic                    clkEnb;
  logic                    pushLoop;
  loopSeqPkg::loopEntryT   newEntry;
  loopSeqPkg::loopCntT     newCount;
  logic                    popLoop;
  logic                    pcValid;
  logic [`LOOP_ADDR_W-1:0] pc;
  logic                    flagIn;
  loopSeqPkg::loopEventT   evt;
  loopSeqPkg::loopEntryT   topEntry;
  loopSeqPkg::loopCntT     topCount;
  logic                    stkEmpty;
  logic                    stkFull;
  logic                    overflow;

  integer seed;

  // reference stacks, level = number of live entries
  loopSeqPkg::loopEntryT modelLoop [`LOOP_DEPTH];
  loopSeqPkg::loopCntT   modelCnt [`LOOP_DEPTH];
  int                    loopLevel;
  int                    cntLevel;
  logic                  modelOvf;

  loopSeqClkGen #(.period(4)) clkGen (.LPSCLK(LPSCLK));

  loopSeqTop dut (
    .LPSCLK   (LPSCLK),
    .T_RST    (T_RST),
    .clkEnb   (clkEnb),
    .pushLoop (pushLoop),
    .newEntry (newEntry),
    .newCount (newCount),
    .popLoop  (popLoop),
    .pcValid  (pcValid),
    .pc       (pc),
    .flagIn   (flagIn),
    .evt      (evt),
    .topEntry (topEntry),
    .topCount (topCount),
    .stkEmpty (stkEmpty),
    .stkFull  (stkFull),
    .overflow (overflow)
  );

  function automatic loopSeqPkg::loopEntryT mkEntry(input logic [`LOOP_ADDR_W-1:0] addr,
                                                    input logic [`LOOP_COND_W-1:0] cond);
    loopSeqPkg::loopEntryT e;
    e.endAddr = addr;
    e.cond    = cond;
    return e;
  endfunction

  function automatic void resetModel();
    loopLevel = 0;
    cntLevel  = 0;
    modelOvf  = 1'b0;
  endfunction

  // a counted entry takes its count along
  function automatic void popModel();
    if (modelLoop[loopLevel-1].cond == loopSeqPkg::condCe) begin
      cntLevel--;
    end
    loopLevel--;
  endfunction

  function automatic expT modelView(input loopSeqPkg::loopEventT ev);
    expT r;
    r          = '0;
    r.evt      = ev;
    r.empty    = (loopLevel == 0);
    r.full     = (loopLevel == `LOOP_DEPTH);
    r.ovf      = modelOvf;
    r.cntValid = (cntLevel != 0);
    if (loopLevel != 0) begin
      r.entry = modelLoop[loopLevel-1];
    end
    if (cntLevel != 0) begin
      r.count = modelCnt[cntLevel-1];
    end
    return r;
  endfunction

  // one enabled edge: push, else pop, else end-address compare
  function automatic expT refStep(input stimT s);
    loopSeqPkg::loopEventT ev;
    loopSeqPkg::loopEntryT t;
    logic                  newCe;
    logic                  leave;
    ev = '0;
    if (!s.clkEnb) begin
      if (s.pushLoop) begin
        newCe = (s.entry.cond == loopSeqPkg::condCe);
        if (loopLevel == `LOOP_DEPTH || (newCe && cntLevel == `LOOP_DEPTH)) begin
          modelOvf = 1'b1;
        end else begin
          modelLoop[loopLevel] = s.entry;
          loopLevel++;
          if (newCe) begin
            modelCnt[cntLevel] = s.count;
            cntLevel++;
          end
        end
      end else if (s.popLoop) begin
        if (loopLevel != 0) begin
          popModel();
        end
      end else if (s.pcValid && loopLevel != 0 && s.pc == modelLoop[loopLevel-1].endAddr) begin
        t = modelLoop[loopLevel-1];
        if (t.cond == loopSeqPkg::condCe) begin
          leave = (modelCnt[cntLevel-1] == 14'd1);
        end else if (t.cond == loopSeqPkg::condFlag) begin
          leave = s.flag;
        end else begin
          leave = 1'b0;  // forever and unknown codes
        end
        ev.endAddr  = t.endAddr;
        ev.loopExit = leave;
        ev.loopBack = !leave;
        if (leave) begin
          popModel();
        end else if (t.cond == loopSeqPkg::condCe) begin
          modelCnt[cntLevel-1] = modelCnt[cntLevel-1] - 1'b1;  // 0 wraps
        end
      end
    end
    return modelView(ev);
  endfunction

  task automatic failRun();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkEvent(input string name, input loopSeqPkg::loopEventT got,
                            input loopSeqPkg::loopEventT exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      failRun();
    end
  endtask

  task automatic checkEntry(input string name, input loopSeqPkg::loopEntryT got,
                            input loopSeqPkg::loopEntryT exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      failRun();
    end
  endtask

  task automatic checkCount(input string name, input loopSeqPkg::loopCntT got,
                            input loopSeqPkg::loopCntT exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      failRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      failRun();
    end
  endtask

  task automatic tick();
    @(posedge LPSCLK);
    #1;
  endtask

  task automatic clearInputs();
    clkEnb   = 1'b0;
    pushLoop = 1'b0;
    popLoop  = 1'b0;
    pcValid  = 1'b0;
    flagIn   = 1'b0;
    newEntry = '0;
    newCount = '0;
    pc       = '0;
  endtask

  task automatic applyReset();
    clearInputs();
    T_RST = 1'b1;
    repeat (16) tick();
    T_RST = 1'b0;
  endtask

  task automatic pushEntry(input loopSeqPkg::loopEntryT e, input loopSeqPkg::loopCntT c);
    pushLoop = 1'b1;
    newEntry = e;
    newCount = c;
    tick();
    pushLoop = 1'b0;
  endtask

  task automatic popEntry();
    popLoop = 1'b1;
    tick();
    popLoop = 1'b0;
  endtask

  task automatic stepPc(input logic [`LOOP_ADDR_W-1:0] addr);
    pcValid = 1'b1;
    pc      = addr;
    tick();
    pcValid = 1'b0;
  endtask

  task automatic runToExit(input logic [`LOOP_ADDR_W-1:0] addr, input int limit,
                           output int backs);
    int   guard;
    logic done;
    backs = 0;
    guard = 0;
    done  = 1'b0;
    while (!done) begin
      if (guard == limit) begin
        $display("timeout: loop ending at %h never exited within %0d passes", addr, limit);
        failRun();
      end
      stepPc(addr - 1'b1);
      stepPc(addr);
      if (evt.loopBack) begin
        backs++;
      end
      if (evt.loopExit) begin
        done = 1'b1;
      end
      guard++;
    end
  endtask

  // model steps on the edge, DUT outputs are read half a cycle later
  initial begin : compareProc
    stimT s;
    expT  e;
    resetModel();
    e = modelView('0);
    forever begin
      @(posedge LPSCLK);
      if (!T_RST) begin
        s.clkEnb   = clkEnb;
        s.pushLoop = pushLoop;
        s.popLoop  = popLoop;
        s.entry    = newEntry;
        s.count    = newCount;
        s.pcValid  = pcValid;
        s.pc       = pc;
        s.flag     = flagIn;
        e          = refStep(s);
      end
      @(negedge LPSCLK);
      if (T_RST) begin
        resetModel();
        e = modelView('0);
      end
      checkEvent("evt", evt, e.evt);
      checkFlag("stkEmpty", stkEmpty, e.empty);
      checkFlag("stkFull", stkFull, e.full);
      checkFlag("overflow", overflow, e.ovf);
      if (!e.empty) begin
        checkEntry("topEntry", topEntry, e.entry);
      end
      if (e.cntValid) begin
        checkCount("topCount", topCount, e.count);
      end
    end
  end

  initial begin : stimProc
    int                    backs;
    int                    i;
    int                    n;
    logic [31:0]           r1;
    logic [31:0]           r2;
    loopSeqPkg::loopEntryT saved [5];
    seed = 32'hd1570d3d;
    applyReset();

    // empty stack ignores any pc
    for (n = 0; n < 20; n++) begin
      r1      = $random(seed);
      pcValid = r1[0];
      flagIn  = r1[1];
      pc      = r1[31:14];
      tick();
      checkFlag("stkEmpty", stkEmpty, 1'b1);
    end
    clearInputs();

    // counted loop of 3
    pushEntry(mkEntry(18'h00100, loopSeqPkg::condCe), 14'd3);
    runToExit(18'h00100, 10, backs);
    checkCount("loopBack passes", loopSeqPkg::loopCntT'(backs), 14'd2);
    checkFlag("stkEmpty", stkEmpty, 1'b1);

    // flag loop around a counted loop
    pushEntry(mkEntry(18'h00200, loopSeqPkg::condFlag), 14'd0);
    pushEntry(mkEntry(18'h00180, loopSeqPkg::condCe), 14'd2);
    flagIn = 1'b1;  // inner loop ignores it
    runToExit(18'h00180, 10, backs);
    checkCount("inner loopBack passes", loopSeqPkg::loopCntT'(backs), 14'd1);
    checkEntry("topEntry", topEntry, mkEntry(18'h00200, loopSeqPkg::condFlag));
    flagIn = 1'b0;
    repeat (2) begin
      stepPc(18'h00200);
      checkFlag("evt.loopBack", evt.loopBack, 1'b1);
    end
    flagIn = 1'b1;
    stepPc(18'h00200);
    checkFlag("evt.loopExit", evt.loopExit, 1'b1);
    checkFlag("stkEmpty", stkEmpty, 1'b1);
    clearInputs();

    // fill, overfill, then drain in LIFO order
    applyReset();
    for (i = 0; i < 5; i++) begin
      saved[i] = mkEntry(18'h01000 + `LOOP_ADDR_W'(i * 16),
                         (i % 2 == 1) ? loopSeqPkg::condCe : loopSeqPkg::condForever);
      pushEntry(saved[i], loopSeqPkg::loopCntT'(7 + i));
      checkFlag("stkFull", stkFull, (i >= 3));
      checkFlag("overflow", overflow, (i == 4));
    end
    checkEntry("topEntry", topEntry, saved[3]);
    for (i = 3; i >= 0; i--) begin
      checkEntry("topEntry", topEntry, saved[i]);
      popEntry();
    end
    checkFlag("stkEmpty", stkEmpty, 1'b1);

    // frozen cycles, then push and pop masking an end hit
    applyReset();
    pushEntry(mkEntry(18'h00300, loopSeqPkg::condCe), 14'd5);
    clkEnb   = 1'b1;
    pushLoop = 1'b1;
    popLoop  = 1'b1;
    newEntry = mkEntry(18'h003ff, loopSeqPkg::condFlag);
    newCount = 14'd9;
    pcValid  = 1'b1;
    pc       = 18'h00300;
    flagIn   = 1'b1;
    repeat (4) begin
      tick();
      checkEvent("evt", evt, '0);
      checkEntry("topEntry", topEntry, mkEntry(18'h00300, loopSeqPkg::condCe));
      checkCount("topCount", topCount, 14'd5);
      checkFlag("overflow", overflow, 1'b0);
    end
    clearInputs();
    pushLoop = 1'b1;
    newEntry = mkEntry(18'h00340, loopSeqPkg::condForever);
    pcValid  = 1'b1;
    pc       = 18'h00300;
    tick();
    clearInputs();
    checkEvent("evt", evt, '0);
    checkEntry("topEntry", topEntry, mkEntry(18'h00340, loopSeqPkg::condForever));
    popLoop = 1'b1;
    pcValid = 1'b1;
    pc      = 18'h00340;
    tick();
    clearInputs();
    checkEvent("evt", evt, '0);
    checkEntry("topEntry", topEntry, mkEntry(18'h00300, loopSeqPkg::condCe));
    stepPc(18'h00300);
    checkFlag("evt.loopBack", evt.loopBack, 1'b1);
    checkCount("topCount", topCount, 14'd4);
    popEntry();
    checkFlag("stkEmpty", stkEmpty, 1'b1);

    // random mix, end addresses from a small set so compares hit
    applyReset();
    for (n = 0; n < 2000; n++) begin
      r1       = $random(seed);
      r2       = $random(seed);
      clkEnb   = (r1[3:0] == 4'd0);
      pushLoop = (r1[5:4] == 2'd0);
      popLoop  = (r1[8:6] == 3'd0);
      pcValid  = r1[9];
      flagIn   = r1[10];
      newEntry = mkEntry(18'h00040 + {r1[12:11], 4'h0},
                         r1[13] ? r1[17:14] : {2'b00, r1[19:18]});
      newCount = {11'd0, r1[22:20]};
      pc       = r1[23] ? r2[17:0] : 18'h00040 + {r1[25:24], 4'h0};
      tick();
    end
    clearInputs();
    tick();
    @(negedge LPSCLK);
    #1;
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/loopSeqPkg.sv
design/hwStack.sv
design/loopCtrl.sv
design/loopSeqTop.sv
tb/loopSeqClkGen.sv
tb/loopSeqTb.sv

// ==== Bender.yml ====
package:
  name: loop_seq

sources:
  - include_dirs:
      - design
    files:
      - design/loopSeqPkg.sv
      - design/hwStack.sv
      - design/loopCtrl.sv
      - design/loopSeqTop.sv

  - target: test
    include_dirs:
      - design
    files:
      - tb/loopSeqClkGen.sv
      - tb/loopSeqTb.sv
